// ==== hdl/letc_core_pkg.sv ====
// Pipeline-level types passed between the decode and execute stages of the core
`default_nettype none

`include "letc_macros.svh"

package letc_core_pkg;

    // PC without the two always-zero low bits
    typedef logic [`LETC_XLEN-3:0] pc_word_t;

    // ALU operations selected by decode
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

endpackage : letc_core_pkg

`default_nettype wire

// ==== hdl/letc_core_rf.sv ====
// Integer register file with two combinational read ports for decode and one write-back port
`default_nettype none

`include "letc_macros.svh"

module letc_core_rf (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,

    // Read ports indexed straight from decode
    input  wire letc_pkg::reg_idx_t i_rs1_idx,
    input  wire letc_pkg::reg_idx_t i_rs2_idx,
    output letc_pkg::word_t         o_rs1_rdata,
    output letc_pkg::word_t         o_rs2_rdata,

    // Write port from the write-back register
    input  wire logic               i_wr_en,
    input  wire letc_pkg::reg_idx_t i_wr_idx,
    input  wire letc_pkg::word_t    i_wr_data
);
    import letc_pkg::*;

    // Only x1 to x31 have storage
    word_t regs [1:`LETC_NUM_REGS-1];

    // x0 reads zero and a same-cycle write wins over the stored value
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t val;
        val = '0;
        if (idx != '0) begin
            if (i_wr_en && (i_wr_idx == idx)) begin
                val = i_wr_data;
            end else begin
                val = regs[idx];
            end
        end
        return val;
    endfunction

    always_comb begin
        o_rs1_rdata = read_reg(i_rs1_idx);
        o_rs2_rdata = read_reg(i_rs2_idx);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `LETC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx != '0)) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // A retired write to x0 must leave x0 reading zero afterwards
    rf_x0_stays_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_en && (i_wr_idx == '0)) |=>
            ((i_rs1_idx != '0) || (o_rs1_rdata == '0)) &&
            ((i_rs2_idx != '0) || (o_rs2_rdata == '0)))
        else $error("x0 read nonzero after a write to x0");

endmodule : letc_core_rf

`default_nettype wire

// ==== hdl/letc_core_stage_d.sv ====
// Decode stage that turns one instruction word into registered operands and ALU controls for E1
`default_nettype none

`include "letc_macros.svh"

module letc_core_stage_d (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,

    // Instruction port standing in for F2
    input  wire logic                    i_instr_valid,
    input  wire letc_pkg::word_t         i_instr,
    input  wire letc_core_pkg::pc_word_t i_pc_word,

    // Register file read ports
    output letc_pkg::reg_idx_t           o_rs1_idx,
    output letc_pkg::reg_idx_t           o_rs2_idx,
    input  wire letc_pkg::word_t         i_rs1_rdata,
    input  wire letc_pkg::word_t         i_rs2_rdata,

    // Result E1 is computing this cycle
    input  wire logic                    i_fwd_valid,
    input  wire letc_pkg::reg_idx_t      i_fwd_rd_idx,
    input  wire letc_pkg::word_t         i_fwd_data,

    // Registered toward E1
    output logic                         o_d_to_e1_valid,
    output letc_core_pkg::pc_word_t      o_d_to_e1_pc_word,
    output letc_pkg::word_t              o_d_to_e1_rs1_val,
    output letc_pkg::word_t              o_d_to_e1_rs2_val,
    output letc_pkg::word_t              o_d_to_e1_imm,
    output letc_core_pkg::alu_op_e       o_d_to_e1_alu_op,
    output logic                         o_d_to_e1_use_imm,
    output letc_pkg::reg_idx_t           o_d_to_e1_rd_idx,
    output logic                         o_illegal
);
    import letc_pkg::*;
    import letc_core_pkg::*;

    opcode_e  opcode;
    reg_idx_t rd_idx;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    funct3_t  funct3;
    funct7_t  funct7;

    word_t    imm;
    alu_op_e  base_op;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     illegal;

    // Field extraction
    always_comb begin
        opcode = opcode_e'(i_instr[6:2]);
        rd_idx = i_instr[11:7];
        // LUI bits 19:15 are immediate so read x0 instead
        rs1_idx = (opcode == OPCODE_LUI) ? '0 : i_instr[19:15];
        rs2_idx = i_instr[24:20];
        funct3 = i_instr[14:12];
        funct7 = i_instr[31:25];
    end

    assign o_rs1_idx = rs1_idx;
    assign o_rs2_idx = rs2_idx;

    // Operation named by funct3 alone
    always_comb begin
        case (funct3)
            FUNCT3_ADD_SUB: base_op = ALU_ADD;
            FUNCT3_SLL:     base_op = ALU_SLL;
            FUNCT3_SLT:     base_op = ALU_SLT;
            FUNCT3_SLTU:    base_op = ALU_SLTU;
            FUNCT3_XOR:     base_op = ALU_XOR;
            FUNCT3_SRL_SRA: base_op = ALU_SRL;
            FUNCT3_OR:      base_op = ALU_OR;
            default:        base_op = ALU_AND;
        endcase
    end

    // Control and immediate decode
    always_comb begin
        alu_op = ALU_ADD;
        use_imm = 1'b0;
        imm = '0;
        illegal = 1'b0;
        case (opcode)
            OPCODE_OP: begin
                alu_op = base_op;
                if (funct7 == FUNCT7_ALT) begin
                    if (funct3 == FUNCT3_ADD_SUB) begin
                        alu_op = ALU_SUB;
                    end else if (funct3 == FUNCT3_SRL_SRA) begin
                        alu_op = ALU_SRA;
                    end else begin
                        illegal = 1'b1;
                    end
                end else if (funct7 != FUNCT7_ZERO) begin
                    illegal = 1'b1;
                end
            end
            OPCODE_OP_IMM: begin
                alu_op = base_op;
                use_imm = 1'b1;
                // Sign-extended I-type immediate
                imm = {{(`LETC_XLEN-12){i_instr[31]}}, i_instr[31:20]};
                // funct7 only constrains the shifts and is plain immediate elsewhere
                if (funct3 == FUNCT3_SLL) begin
                    illegal = (funct7 != FUNCT7_ZERO);
                end else if (funct3 == FUNCT3_SRL_SRA) begin
                    if (funct7 == FUNCT7_ALT) begin
                        alu_op = ALU_SRA;
                    end else if (funct7 != FUNCT7_ZERO) begin
                        illegal = 1'b1;
                    end
                end
            end
            OPCODE_LUI: begin
                // x0 plus the U immediate
                use_imm = 1'b1;
                imm = {i_instr[31:12], 12'b0};
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // Take E1's result over the RF when it targets this source
    function automatic word_t fwd_select(input reg_idx_t src, input word_t rf_val);
        logic hit;
        hit = i_fwd_valid && (i_fwd_rd_idx != '0) && (i_fwd_rd_idx == src);
        return hit ? i_fwd_data : rf_val;
    endfunction

    // Control flops
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_d_to_e1_valid <= 1'b0;
            o_illegal <= 1'b0;
        end else begin
            o_d_to_e1_valid <= i_instr_valid && !illegal;
            o_illegal <= i_instr_valid && illegal;
        end
    end

    // Payload flops
    always_ff @(posedge i_clk) begin
        o_d_to_e1_pc_word <= i_pc_word;
        o_d_to_e1_rs1_val <= fwd_select(rs1_idx, i_rs1_rdata);
        o_d_to_e1_rs2_val <= fwd_select(rs2_idx, i_rs2_rdata);
        o_d_to_e1_imm <= imm;
        o_d_to_e1_alu_op <= alu_op;
        o_d_to_e1_use_imm <= use_imm;
        o_d_to_e1_rd_idx <= rd_idx;
    end

    // An illegal instruction is a bubble and never a live op in E1
    d_illegal_is_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_illegal && o_d_to_e1_valid))
        else $error("illegal flag raised with a valid D to E1 op");

endmodule : letc_core_stage_d

`default_nettype wire

// ==== hdl/letc_core_stage_e1.sv ====
// Execute stage that runs the ALU on decoded operands and feeds both decode and write-back
`default_nettype none

module letc_core_stage_e1 (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,

    // From D
    input  wire logic                    i_d_to_e1_valid,
    input  wire letc_core_pkg::pc_word_t i_d_to_e1_pc_word,
    input  wire letc_pkg::word_t         i_d_to_e1_rs1_val,
    input  wire letc_pkg::word_t         i_d_to_e1_rs2_val,
    input  wire letc_pkg::word_t         i_d_to_e1_imm,
    input  wire letc_core_pkg::alu_op_e  i_d_to_e1_alu_op,
    input  wire logic                    i_d_to_e1_use_imm,
    input  wire letc_pkg::reg_idx_t      i_d_to_e1_rd_idx,

    // Combinational result for the instruction behind this one
    output logic                         o_fwd_valid,
    output letc_pkg::reg_idx_t           o_fwd_rd_idx,
    output letc_pkg::word_t              o_fwd_data,

    // Write-back register that doubles as the retire port
    output logic                         o_wb_valid,
    output letc_pkg::reg_idx_t           o_wb_rd_idx,
    output letc_pkg::word_t              o_wb_data
);
    import letc_pkg::*;
    import letc_core_pkg::*;

    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_result;

    // Operand select
    always_comb begin
        op_a = i_d_to_e1_rs1_val;
        op_b = i_d_to_e1_use_imm ? i_d_to_e1_imm : i_d_to_e1_rs2_val;
        // RV32I shifts use the low five bits only
        shamt = op_b[4:0];
    end

    // ALU
    always_comb begin
        case (i_d_to_e1_alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result = word_t'(op_a < op_b);
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Forward path to D
    assign o_fwd_valid = i_d_to_e1_valid;
    assign o_fwd_rd_idx = i_d_to_e1_rd_idx;
    assign o_fwd_data = alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_d_to_e1_valid;
        end
    end

    // Result and destination qualified by o_wb_valid
    always_ff @(posedge i_clk) begin
        o_wb_rd_idx <= i_d_to_e1_rd_idx;
        o_wb_data <= alu_result;
    end

    // D comes out of reset empty so nothing retires one cycle later
    e1_no_wb_after_reset: assert property (@(posedge i_clk)
        $rose(i_rst_n) |=> !o_wb_valid)
        else $error("write-back valid right after reset");

    // A live op carries a known PC all the way from the instruction port
    e1_pc_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_d_to_e1_valid |-> !$isunknown(i_d_to_e1_pc_word))
        else $error("valid E1 op with unknown PC");

endmodule : letc_core_stage_e1

`default_nettype wire

// ==== hdl/letc_core_top.sv ====
// Core top that joins decode, execute and the register file between instruction and retire ports
`default_nettype none

module letc_core_top (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,

    // Instruction port
    input  wire logic                    i_instr_valid,
    input  wire letc_pkg::word_t         i_instr,
    input  wire letc_core_pkg::pc_word_t i_pc_word,

    // Retire port
    output logic                         o_wb_valid,
    output letc_pkg::reg_idx_t           o_wb_rd_idx,
    output letc_pkg::word_t              o_wb_data,
    output logic                         o_illegal
);
    import letc_pkg::*;
    import letc_core_pkg::*;

    // RF read
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_rdata;
    word_t    rs2_rdata;

    // D to E1
    logic     d_to_e1_valid;
    pc_word_t d_to_e1_pc_word;
    word_t    d_to_e1_rs1_val;
    word_t    d_to_e1_rs2_val;
    word_t    d_to_e1_imm;
    alu_op_e  d_to_e1_alu_op;
    logic     d_to_e1_use_imm;
    reg_idx_t d_to_e1_rd_idx;

    // E1 back to D
    logic     fwd_valid;
    reg_idx_t fwd_rd_idx;
    word_t    fwd_data;

    letc_core_stage_d stage_d (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_instr_valid     (i_instr_valid),
        .i_instr           (i_instr),
        .i_pc_word         (i_pc_word),
        .o_rs1_idx         (rs1_idx),
        .o_rs2_idx         (rs2_idx),
        .i_rs1_rdata       (rs1_rdata),
        .i_rs2_rdata       (rs2_rdata),
        .i_fwd_valid       (fwd_valid),
        .i_fwd_rd_idx      (fwd_rd_idx),
        .i_fwd_data        (fwd_data),
        .o_d_to_e1_valid   (d_to_e1_valid),
        .o_d_to_e1_pc_word (d_to_e1_pc_word),
        .o_d_to_e1_rs1_val (d_to_e1_rs1_val),
        .o_d_to_e1_rs2_val (d_to_e1_rs2_val),
        .o_d_to_e1_imm     (d_to_e1_imm),
        .o_d_to_e1_alu_op  (d_to_e1_alu_op),
        .o_d_to_e1_use_imm (d_to_e1_use_imm),
        .o_d_to_e1_rd_idx  (d_to_e1_rd_idx),
        .o_illegal         (o_illegal)
    );

    letc_core_stage_e1 stage_e1 (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_d_to_e1_valid   (d_to_e1_valid),
        .i_d_to_e1_pc_word (d_to_e1_pc_word),
        .i_d_to_e1_rs1_val (d_to_e1_rs1_val),
        .i_d_to_e1_rs2_val (d_to_e1_rs2_val),
        .i_d_to_e1_imm     (d_to_e1_imm),
        .i_d_to_e1_alu_op  (d_to_e1_alu_op),
        .i_d_to_e1_use_imm (d_to_e1_use_imm),
        .i_d_to_e1_rd_idx  (d_to_e1_rd_idx),
        .o_fwd_valid       (fwd_valid),
        .o_fwd_rd_idx      (fwd_rd_idx),
        .o_fwd_data        (fwd_data),
        .o_wb_valid        (o_wb_valid),
        .o_wb_rd_idx       (o_wb_rd_idx),
        .o_wb_data         (o_wb_data)
    );

    // Written from the retire port itself
    letc_core_rf rf (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rs1_idx   (rs1_idx),
        .i_rs2_idx   (rs2_idx),
        .o_rs1_rdata (rs1_rdata),
        .o_rs2_rdata (rs2_rdata),
        .i_wr_en     (o_wb_valid),
        .i_wr_idx    (o_wb_rd_idx),
        .i_wr_data   (o_wb_data)
    );

endmodule : letc_core_top

`default_nettype wire

// ==== hdl/letc_macros.svh ====
// Core-wide width and size constants, included by the packages and by RTL that sizes storage
`ifndef LETC_MACROS_SVH
`define LETC_MACROS_SVH

// Data path and integer register width
`define LETC_XLEN 32

// Architectural registers, x0 included
`define LETC_NUM_REGS 32

// Bits to name one register
`define LETC_REG_IDX_W 5

`endif

// ==== hdl/letc_pkg.sv ====
// ISA-level types and field encodings shared by every block that looks at an RV32I word
`default_nettype none

`include "letc_macros.svh"

package letc_pkg;

    // One architectural data word
    typedef logic [`LETC_XLEN-1:0] word_t;

    // Register number as it appears in rd, rs1 and rs2
    typedef logic [`LETC_REG_IDX_W-1:0] reg_idx_t;

    // Major opcode, instruction bits 6 to 2
    // Codes outside this list stay unnamed and decode as illegal
    typedef enum logic [4:0] {
        OPCODE_OP_IMM = 5'b00100,
        OPCODE_OP     = 5'b01100,
        OPCODE_LUI    = 5'b01101
    } opcode_e;

    // Minor function fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // funct3 values shared by OP and OP-IMM
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // Base encoding
    localparam funct7_t FUNCT7_ZERO = 7'b0000000;
    // Alternate encoding, sub and sra/srai
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage : letc_pkg

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

TOP=letc_core_tb
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module "$TOP" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi

echo "Simulation PASSED"
exit 0

// ==== test/letc_core_tb.sv ====
// Self-checking testbench for the core top, runs a directed table then an LFSR-random stream
`default_nettype none

`include "letc_macros.svh"

module letc_core_tb;
    import letc_pkg::*;
    import letc_core_pkg::*;

    localparam int          N_RANDOM  = 200;
    localparam logic [31:0] LFSR_SEED = 32'd73430;

    logic     i_clk;
    logic     i_rst_n;
    logic     i_instr_valid;
    word_t    i_instr;
    pc_word_t i_pc_word;
    logic     o_wb_valid;
    reg_idx_t o_wb_rd_idx;
    word_t    o_wb_data;
    logic     o_illegal;

    // Directed table, one row per instruction
    word_t    tbl_instr[$];
    logic     tbl_retire[$];
    reg_idx_t tbl_rd[$];
    word_t    tbl_val[$];

    // Outstanding expectations, oldest first
    reg_idx_t exp_rd_q[$];
    word_t    exp_val_q[$];
    int       exp_cyc_q[$];
    int       ill_cyc_q[$];

    // Architectural state as the ISA sees it at issue
    word_t       ref_regs [0:`LETC_NUM_REGS-1];
    logic [31:0] lfsr_state;
    int          cycle;
    int          cycle_limit;
    int          fail_count;
    int          other_count;

    letc_core_top UUT (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_pc_word     (i_pc_word),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd_idx   (o_wb_rd_idx),
        .o_wb_data     (o_wb_data),
        .o_illegal     (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // R-type, OP major opcode
    function automatic word_t op_word(input funct7_t f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3,
                                      input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // I-type, OP-IMM major opcode
    function automatic word_t op_imm_word(input logic [11:0] imm, input reg_idx_t rs1,
                                          input funct3_t f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Right-shifting Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
    endfunction

    // n fresh bits, one LFSR step each
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_word(input word_t act, input word_t exp, input string what);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, act, exp);
            fail_count++;
        end
    endtask

    task automatic check_idx(input reg_idx_t act, input reg_idx_t exp, input string what);
        if (act !== exp) begin
            $display("Fail at %0t: %s is x%0d, expected x%0d", $time, what, act, exp);
            fail_count++;
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, what, act, exp);
            fail_count++;
        end
    endtask

    // RV32I rules for OP, OP-IMM and LUI against the model registers
    task automatic predict(input word_t instr, output logic legal, output reg_idx_t rd,
                           output word_t val);
        logic [6:0]         opc;
        funct3_t            f3;
        funct7_t            f7;
        word_t              a;
        word_t              b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        opc = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        rd = instr[11:7];
        a = ref_regs[instr[19:15]];
        b = ref_regs[instr[24:20]];
        legal = 1'b1;
        val = '0;
        if (opc == 7'b0110111) begin
            val = {instr[31:12], 12'b0};
        end else if ((opc == 7'b0110011) || (opc == 7'b0010011)) begin
            if (opc == 7'b0110011) begin
                // Alternate funct7 only for sub and sra
                legal = (f7 == 7'h00) ||
                        ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            end else begin
                b = {{20{instr[31]}}, instr[31:20]};
                // Upper immediate bits matter for shifts only
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
            end
            sa = a;
            sb = b;
            case (f3)
                3'd0: begin
                    if ((opc == 7'b0110011) && (f7 == 7'h20)) begin
                        val = a - b;
                    end else begin
                        val = a + b;
                    end
                end
                3'd1: val = a << b[4:0];
                3'd2: val = (sa < sb) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (f7 == 7'h20) begin
                        val = sa >>> b[4:0];
                    end else begin
                        val = a >> b[4:0];
                    end
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
    endtask

    // Small register range so hazards come often
    function automatic word_t random_instr();
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] alt;
        logic [31:0] imm;
        funct7_t     f7;
        word_t       w;
        cls = take_bits(3);
        rd = take_bits(3);
        rs1 = take_bits(3);
        rs2 = take_bits(3);
        f3 = take_bits(3);
        alt = take_bits(1);
        case (cls[2:0])
            3'd0, 3'd1, 3'd2: begin
                imm = take_bits(12);
                if (f3[2:0] == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3[2:0] == 3'd5) begin
                    imm[11:5] = alt[0] ? 7'h20 : 7'h00;
                end
                w = op_imm_word(imm[11:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            3'd3, 3'd4: begin
                f7 = 7'h00;
                if (alt[0] && ((f3[2:0] == 3'd0) || (f3[2:0] == 3'd5))) begin
                    f7 = 7'h20;
                end
                w = op_word(f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            3'd5: begin
                imm = take_bits(20);
                w = lui_word(imm[19:0], rd[4:0]);
            end
            3'd6: begin
                // Random funct7, mostly illegal
                imm = take_bits(7);
                w = op_word(imm[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0]);
            end
            default: begin
                // Any major opcode, low bits kept at 11
                w = take_bits(32);
                w[1:0] = 2'b11;
            end
        endcase
        return w;
    endfunction

    // Sample the retire port and illegal flag
    task automatic watch_outputs();
        reg_idx_t rd;
        word_t    val;
        int       cyc;
        if (o_wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("Unexpected retire at time %0t with nothing outstanding", $time);
                other_count++;
            end else begin
                rd = exp_rd_q.pop_front();
                val = exp_val_q.pop_front();
                cyc = exp_cyc_q.pop_front();
                check_idx(o_wb_rd_idx, rd, "retire rd");
                check_word(o_wb_data, val, "retire data");
                check_flag(cycle == cyc, 1'b1, "retire two cycles after issue");
            end
        end
        if (o_illegal) begin
            if (ill_cyc_q.size() == 0) begin
                $display("Unexpected illegal pulse at time %0t", $time);
                other_count++;
            end else begin
                cyc = ill_cyc_q.pop_front();
                check_flag(cycle == cyc, 1'b1, "illegal pulse one cycle after issue");
            end
        end
    endtask

    // One instruction on the falling edge, expectations queued
    task automatic send(input word_t instr, input logic retire, input reg_idx_t rd,
                        input word_t val);
        @(negedge i_clk);
        watch_outputs();
        i_instr_valid = 1'b1;
        i_instr = instr;
        i_pc_word = i_pc_word + 30'd1;
        if (retire) begin
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(val);
            exp_cyc_q.push_back(cycle + 2);
            if (rd != '0) begin
                ref_regs[rd] = val;
            end
        end else begin
            ill_cyc_q.push_back(cycle + 1);
        end
    endtask

    // Port not valid, junk on the instruction bus
    task automatic idle_cycle();
        @(negedge i_clk);
        watch_outputs();
        i_instr_valid = 1'b0;
        i_instr = 32'hFFFF_FFFF;
    endtask

    task automatic add_row(input word_t instr, input logic retire, input reg_idx_t rd,
                           input word_t val);
        tbl_instr.push_back(instr);
        tbl_retire.push_back(retire);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
    endtask

    task automatic build_table();
        // Every register reads zero out of reset
        for (int p = 0; p < 16; p++) begin
            add_row(op_word(7'h00, reg_idx_t'(31 - p), reg_idx_t'(p), 3'd0, 5'd0),
                    1'b1, 5'd0, 32'h0);
        end
        // LUI and OP-IMM
        add_row(lui_word(20'h12345, 5'd1), 1'b1, 5'd1, 32'h1234_5000);
        add_row(op_imm_word(12'hFFF, 5'd0, 3'd0, 5'd2), 1'b1, 5'd2, 32'hFFFF_FFFF);
        add_row(op_imm_word(12'h678, 5'd1, 3'd0, 5'd3), 1'b1, 5'd3, 32'h1234_5678);
        add_row(op_imm_word(12'h000, 5'd2, 3'd2, 5'd4), 1'b1, 5'd4, 32'h1);
        add_row(op_imm_word(12'hFFF, 5'd1, 3'd3, 5'd5), 1'b1, 5'd5, 32'h1);
        add_row(op_imm_word(12'hFFF, 5'd3, 3'd4, 5'd6), 1'b1, 5'd6, 32'hEDCB_A987);
        add_row(op_imm_word(12'h7F0, 5'd0, 3'd6, 5'd7), 1'b1, 5'd7, 32'h0000_07F0);
        add_row(op_imm_word(12'h0F0, 5'd3, 3'd7, 5'd8), 1'b1, 5'd8, 32'h0000_0070);
        add_row(op_imm_word(12'h004, 5'd3, 3'd1, 5'd9), 1'b1, 5'd9, 32'h2345_6780);
        add_row(op_imm_word(12'h008, 5'd6, 3'd5, 5'd10), 1'b1, 5'd10, 32'h00ED_CBA9);
        add_row(op_imm_word(12'h408, 5'd6, 3'd5, 5'd11), 1'b1, 5'd11, 32'hFFED_CBA9);
        add_row(op_imm_word(12'h987, 5'd3, 3'd0, 5'd12), 1'b1, 5'd12, 32'h1234_4FFF);
        // OP
        add_row(op_word(7'h00, 5'd6, 5'd3, 3'd0, 5'd13), 1'b1, 5'd13, 32'hFFFF_FFFF);
        add_row(op_word(7'h20, 5'd3, 5'd7, 3'd0, 5'd14), 1'b1, 5'd14, 32'hEDCB_B178);
        add_row(op_word(7'h00, 5'd10, 5'd3, 3'd1, 5'd15), 1'b1, 5'd15, 32'h68AC_F000);
        add_row(op_word(7'h00, 5'd3, 5'd6, 3'd2, 5'd16), 1'b1, 5'd16, 32'h1);
        add_row(op_word(7'h00, 5'd3, 5'd6, 3'd3, 5'd17), 1'b1, 5'd17, 32'h0);
        add_row(op_word(7'h00, 5'd1, 5'd3, 3'd4, 5'd18), 1'b1, 5'd18, 32'h0000_0678);
        add_row(op_word(7'h00, 5'd4, 5'd2, 3'd5, 5'd19), 1'b1, 5'd19, 32'h7FFF_FFFF);
        add_row(op_word(7'h20, 5'd4, 5'd6, 3'd5, 5'd20), 1'b1, 5'd20, 32'hF6E5_D4C3);
        add_row(op_word(7'h00, 5'd8, 5'd1, 3'd6, 5'd21), 1'b1, 5'd21, 32'h1234_5070);
        add_row(op_word(7'h00, 5'd12, 5'd6, 3'd7, 5'd22), 1'b1, 5'd22, 32'h0000_0987);
        // Dependency chain at distances 1, 2 and 3
        add_row(op_imm_word(12'h005, 5'd0, 3'd0, 5'd23), 1'b1, 5'd23, 32'h5);
        add_row(op_imm_word(12'h001, 5'd23, 3'd0, 5'd24), 1'b1, 5'd24, 32'h6);
        add_row(op_word(7'h00, 5'd24, 5'd23, 3'd0, 5'd25), 1'b1, 5'd25, 32'hB);
        add_row(op_word(7'h00, 5'd25, 5'd23, 3'd0, 5'd26), 1'b1, 5'd26, 32'h10);
        add_row(op_word(7'h20, 5'd26, 5'd24, 3'd0, 5'd27), 1'b1, 5'd27, 32'hFFFF_FFF6);
        // Writes to x0 retire but x0 still reads zero
        add_row(op_imm_word(12'h055, 5'd0, 3'd0, 5'd0), 1'b1, 5'd0, 32'h55);
        add_row(op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd29), 1'b1, 5'd29, 32'h0);
        add_row(op_imm_word(12'h000, 5'd2, 3'd0, 5'd0), 1'b1, 5'd0, 32'hFFFF_FFFF);
        add_row(op_imm_word(12'h001, 5'd0, 3'd6, 5'd30), 1'b1, 5'd30, 32'h1);
        add_row(op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd31), 1'b1, 5'd31, 32'h0);
        // Load opcode, mul-style funct7, xor with alt funct7, slli with alt funct7
        add_row(32'h0000_2083, 1'b0, 5'd0, 32'h0);
        add_row(op_word(7'h01, 5'd2, 5'd3, 3'd0, 5'd1), 1'b0, 5'd0, 32'h0);
        add_row(op_word(7'h20, 5'd2, 5'd3, 3'd4, 5'd1), 1'b0, 5'd0, 32'h0);
        add_row(op_imm_word(12'h401, 5'd3, 3'd1, 5'd1), 1'b0, 5'd0, 32'h0);
        // x1 untouched by the bubbles
        add_row(op_word(7'h00, 5'd0, 5'd1, 3'd0, 5'd5), 1'b1, 5'd5, 32'h1234_5000);
    endtask

    // Cycle counter and run limit
    initial begin : watchdog
        cycle = 0;
        wait (cycle_limit > 0);
        while (cycle < cycle_limit) begin
            @(posedge i_clk);
            cycle = cycle + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        word_t    instr;
        logic     legal;
        reg_idx_t rd;
        word_t    val;
        i_rst_n = 1'b0;
        i_instr_valid = 1'b0;
        i_instr = '0;
        i_pc_word = '0;
        fail_count = 0;
        other_count = 0;
        lfsr_state = LFSR_SEED;
        for (int r = 0; r < `LETC_NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        build_table();
        cycle_limit = tbl_instr.size() + N_RANDOM + 20;

        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;

        // Quiet after reset
        repeat (4) begin
            idle_cycle();
            check_flag(o_wb_valid, 1'b0, "retire valid while idle");
            check_flag(o_illegal, 1'b0, "illegal flag while idle");
        end

        for (int n = 0; n < tbl_instr.size(); n++) begin
            send(tbl_instr[n], tbl_retire[n], tbl_rd[n], tbl_val[n]);
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            instr = random_instr();
            predict(instr, legal, rd, val);
            send(instr, legal, rd, val);
        end

        // Two cycles of latency plus one spare
        repeat (3) idle_cycle();

        if (exp_rd_q.size() != 0) begin
            $display("%0d expected retires never appeared", exp_rd_q.size());
            other_count++;
        end
        if (ill_cyc_q.size() != 0) begin
            $display("%0d expected illegal pulses never appeared", ill_cyc_q.size());
            other_count++;
        end

        $display("Errors: %0d value mismatches, %0d other failures", fail_count, other_count);
        if ((fail_count + other_count) == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : letc_core_tb

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/letc_pkg.sv
hdl/letc_core_pkg.sv
hdl/letc_core_rf.sv
hdl/letc_core_stage_d.sv
hdl/letc_core_stage_e1.sv
hdl/letc_core_top.sv
test/letc_core_tb.sv
